/* dv/mat_engine_chk.sv */
`timescale 1ns/1ps
/*
 * Concurrent checks on the execute status, bound into matmul_execute.
 * Busy length is fixed at MAT_N * (MAT_N + 1) cycles per computation.
 * All checks are disabled while rst_n is low.
 */
module mat_engine_chk (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic busy,
    input logic done
);
    import mat_cfg_pkg::*;

    // Cycles busy has been high so far
    int busy_cnt;
    // Failed assertions so far, seen by the testbench at the end of the run
    int fail_cnt = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt <= 0;
        end else if (busy) begin
            busy_cnt <= busy_cnt + 1;
        end else begin
            busy_cnt <= 0;
        end
    end

    // ==============================
    // Status properties
    // ==============================
    a_busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else begin
            fail_cnt++;
            $error("busy and done are high together");
        end

    // Busy never runs past its fixed length
    a_busy_max: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> (busy_cnt < MAT_N * (MAT_N + 1)))
        else begin
            fail_cnt++;
            $error("busy stayed high longer than one computation");
        end

    // And never ends early
    a_busy_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(busy) |-> (busy_cnt == MAT_N * (MAT_N + 1)))
        else begin
            fail_cnt++;
            $error("busy fell after the wrong number of cycles");
        end

    a_done_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(done) |-> $past(start))
        else begin
            fail_cnt++;
            $error("done fell without a start being sampled");
        end

endmodule

bind matmul_execute mat_engine_chk u_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .busy  (busy),
    .done  (done)
);

/* dv/mat_engine_tb.sv */
`timescale 1ns/1ps
/*
 * Testbench for the 4x4 signed matrix engine.
 * Cases come from a table of A, B and expected C. Directed entries carry
 * hand-worked results, random entries use a plain reference multiply.
 * Decode adds one cycle, so done rises 21 edges after the OP_START edge.
 * The run stops at the first failing check.
 */
module mat_engine_tb;
    import mat_cfg_pkg::*;
    import mat_ctrl_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int NUM_EL       = MAT_N * MAT_N;
    localparam int NUM_CASES    = 11;
    localparam int NUM_DIRECTED = 3;
    localparam int DONE_LAT     = 21;
    localparam int DONE_WAIT    = 2 * DONE_LAT;
    // Loads, start, compute and readout of one case
    localparam int CASE_CYC     = 2 * NUM_EL + 2 + DONE_LAT + NUM_EL;
    // Table cases plus reset check and the two busy runs, with 2x margin
    localparam int WATCHDOG_NS  = (NUM_CASES + 4) * CASE_CYC * CLK_PERIOD * 2;

    typedef int mat_t [NUM_EL];

    logic              clk;
    logic              rst_n;
    logic              cmd_valid;
    host_op_e          cmd_op;
    logic [ADDR_W-1:0] cmd_addr;
    operand_t          cmd_data;
    logic [ADDR_W-1:0] rd_addr;
    acc_t              rd_data;
    logic              busy;
    logic              done;

    int    seed;
    string case_name [NUM_CASES];
    mat_t  a_tbl [NUM_CASES];
    mat_t  b_tbl [NUM_CASES];
    mat_t  c_tbl [NUM_CASES];

    mat_engine_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .busy      (busy),
        .done      (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_val(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            fail_run($sformatf("ERROR: %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // ==============================
    // Case table
    // ==============================
    // Plain C = A x B, wrapped to the result width
    task automatic ref_multiply(input int idx);
        int                       sum;
        logic signed [ACC_W-1:0] wrapped;
        for (int r = 0; r < MAT_N; r++) begin
            for (int col = 0; col < MAT_N; col++) begin
                sum = 0;
                for (int k = 0; k < MAT_N; k++) begin
                    sum += a_tbl[idx][r * MAT_N + k] * b_tbl[idx][k * MAT_N + col];
                end
                wrapped = sum[ACC_W-1:0];
                c_tbl[idx][r * MAT_N + col] = int'(wrapped);
            end
        end
    endtask

    task automatic fill_tables();
        logic [31:0] rnd;
        case_name[0] = "identity";
        a_tbl[0] = '{1, 0, 0, 0,  0, 1, 0, 0,  0, 0, 1, 0,  0, 0, 0, 1};
        b_tbl[0] = '{-128, 127, -1, 0,  5, -6, 7, -8,  100, -100, 50, -50,  1, 2, 3, 4};
        c_tbl[0] = '{-128, 127, -1, 0,  5, -6, 7, -8,  100, -100, 50, -50,  1, 2, 3, 4};
        // Largest magnitude product, four times per element
        case_name[1] = "all_min";
        a_tbl[1] = '{default: -128};
        b_tbl[1] = '{default: -128};
        c_tbl[1] = '{default: 65536};
        case_name[2] = "mixed_sign";
        a_tbl[2] = '{1, -2, 3, -4,  127, -128, 0, 0,  -1, -1, -1, -1,  2, 0, -3, 0};
        b_tbl[2] = '{1, 2, 3, 4,  -1, -2, -3, -4,  5, 0, -5, 10,  0, -7, 7, 1};
        c_tbl[2] = '{18, 34, -34, 38,  255, 510, 765, 1020,  -5, 7, -2, -11,  -13, 4, 21, -22};
        for (int i = NUM_DIRECTED; i < NUM_CASES; i++) begin
            case_name[i] = $sformatf("random_%0d", i - NUM_DIRECTED);
            for (int e = 0; e < NUM_EL; e++) begin
                rnd = $random(seed);
                a_tbl[i][e] = int'($signed(rnd[7:0]));
                rnd = $random(seed);
                b_tbl[i][e] = int'($signed(rnd[7:0]));
            end
            ref_multiply(i);
        end
    endtask

    // ==============================
    // Host side
    // ==============================
    task automatic send_cmd(input host_op_e op, input logic [ADDR_W-1:0] addr,
                            input operand_t data);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_op    <= op;
        cmd_addr  <= addr;
        cmd_data  <= data;
    endtask

    task automatic load_case(input int idx);
        for (int e = 0; e < NUM_EL; e++) begin
            send_cmd(OP_LOAD_A, ADDR_W'(e), operand_t'(a_tbl[idx][e]));
        end
        for (int e = 0; e < NUM_EL; e++) begin
            send_cmd(OP_LOAD_B, ADDR_W'(e), operand_t'(b_tbl[idx][e]));
        end
    endtask

    // Start, optionally poke commands while busy, then time done
    task automatic run_compute(input string name, input bit poke);
        int n;
        n = 0;
        send_cmd(OP_START, '0, '0);
        // Edge that samples OP_START
        @(posedge clk);
        if (poke) begin
            // Sampled on the edge where busy rises
            cmd_op   <= OP_LOAD_A;
            cmd_addr <= '0;
            cmd_data <= operand_t'(99);
            @(posedge clk);
            n++;
            cmd_op <= OP_START;
            @(negedge clk);
            check_val({name, " busy"}, 1, int'(busy));
            @(posedge clk);
            n++;
        end
        cmd_valid <= 1'b0;
        cmd_op    <= OP_NOP;
        while (n < DONE_WAIT) begin
            @(posedge clk);
            n++;
            @(negedge clk);
            if (done) break;
        end
        if (!done) begin
            fail_run($sformatf("%s: done did not rise within %0d cycles", name, DONE_WAIT));
        end
        check_val({name, " done latency"}, DONE_LAT, n);
    endtask

    task automatic check_result(input int idx, input string tag);
        for (int e = 0; e < NUM_EL; e++) begin
            @(posedge clk);
            rd_addr <= ADDR_W'(e);
            @(negedge clk);
            check_val($sformatf("%s C[%0d][%0d]", tag, e / MAT_N, e % MAT_N),
                      c_tbl[idx][e], int'(rd_data));
        end
    endtask

    task automatic check_reset();
        @(negedge clk);
        check_val("reset busy", 0, int'(busy));
        check_val("reset done", 0, int'(done));
        for (int e = 0; e < NUM_EL; e++) begin
            @(posedge clk);
            rd_addr <= ADDR_W'(e);
            @(negedge clk);
            check_val($sformatf("reset C[%0d]", e), 0, int'(rd_data));
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the test sequence finished");
    end

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_NOP;
        cmd_addr  = '0;
        cmd_data  = '0;
        rd_addr   = '0;
        seed      = 32'h9e27_f83a;
        fill_tables();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        check_reset();
        for (int i = 0; i < NUM_CASES; i++) begin
            load_case(i);
            run_compute(case_name[i], 1'b0);
            check_result(i, case_name[i]);
        end
        // Dropped load and start, then a rerun on the untouched A
        load_case(2);
        run_compute("busy_poke", 1'b1);
        check_result(2, "busy_poke");
        run_compute("busy_rerun", 1'b0);
        check_result(2, "busy_rerun");
        @(posedge clk);
        if (UUT.u_exec.u_chk.fail_cnt != 0) begin
            fail_run("a status assertion in the bound checker failed during the run");
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

/* mat_engine_top.f */
rtl/mat_cfg_pkg.sv
rtl/mat_ctrl_pkg.sv
rtl/host_cmd_decode.sv
rtl/operand_bank.sv
rtl/matmul_execute.sv
rtl/result_store.sv
rtl/mat_engine_top.sv
dv/mat_engine_chk.sv
dv/mat_engine_tb.sv

/* rtl/host_cmd_decode.sv */
`timescale 1ns/1ps
/*
 * Host command decode. Commands are one-cycle strobes with no ready.
 * The command is registered first, so writes and start appear one cycle
 * after the host edge. Every command is dropped while busy is high,
 * including one sampled on the edge where busy rises.
 */
module host_cmd_decode (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    input  mat_ctrl_pkg::host_op_e         cmd_op,
    input  logic [mat_cfg_pkg::ADDR_W-1:0] cmd_addr,
    input  mat_cfg_pkg::operand_t          cmd_data,
    input  logic                           busy,
    output logic                           wr_a,
    output logic                           wr_b,
    output logic [mat_cfg_pkg::ADDR_W-1:0] wr_addr,
    output mat_cfg_pkg::operand_t          wr_data,
    output logic                           start
);
    import mat_ctrl_pkg::*;

    logic     cmd_vld_q;
    host_op_e cmd_op_q;
    logic     cmd_ok;

    // Command strobe and opcode stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_vld_q <= 1'b0;
            cmd_op_q  <= OP_NOP;
        end else begin
            cmd_vld_q <= cmd_valid;
            cmd_op_q  <= cmd_op;
        end
    end

    // Address and data ride along with the strobe
    always_ff @(posedge clk) begin
        wr_addr <= cmd_addr;
        wr_data <= cmd_data;
    end

    // Busy is checked against the registered command
    assign cmd_ok = cmd_vld_q && !busy;

    assign wr_a  = cmd_ok && (cmd_op_q == OP_LOAD_A);
    assign wr_b  = cmd_ok && (cmd_op_q == OP_LOAD_B);
    assign start = cmd_ok && (cmd_op_q == OP_START);

endmodule

/* rtl/mat_cfg_pkg.sv */
/*
 * Sizes and data types for the 4x4 signed integer matrix engine.
 * Operands are 8-bit two's complement. Results are 20-bit, wide enough
 * for four products of -128 x -128 with no overflow.
 * Element addresses are row-major: upper bits row, lower bits column.
 */
package mat_cfg_pkg;

    // ==============================
    // Sizes
    // ==============================
    localparam int MAT_N  = 4;
    // Row or column index
    localparam int IDX_W  = 2;
    // Element address, row then column
    localparam int ADDR_W = 4;
    localparam int OPND_W = 8;
    localparam int ACC_W  = 20;

    // ==============================
    // Data types
    // ==============================
    typedef logic signed [OPND_W-1:0] operand_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // One row of B, column c at index c
    typedef operand_t [MAT_N-1:0] opnd_row_t;
    // One row of C
    typedef acc_t [MAT_N-1:0] acc_row_t;

endpackage

/* rtl/mat_ctrl_pkg.sv */
/*
 * Control encodings for the matrix engine.
 * Host opcodes are 2 bits wide and fixed by the host command port.
 */
package mat_ctrl_pkg;

    // ==============================
    // Host command opcodes
    // ==============================
    typedef enum logic [1:0] {
        OP_NOP    = 2'd0,
        OP_LOAD_A = 2'd1,
        OP_LOAD_B = 2'd2,
        OP_START  = 2'd3
    } host_op_e;

    // Execute FSM states
    typedef enum logic [1:0] {
        EX_IDLE,
        EX_MAC,
        EX_STORE
    } exec_state_e;

endpackage

/* rtl/mat_engine_top.sv */
`timescale 1ns/1ps
/*
 * Signed 4x4 integer matrix engine, C = A x B.
 * Commands are one-cycle strobes and are dropped while busy.
 * Decode adds one cycle: done rises 21 edges after the OP_START edge.
 * Results read back combinationally by row-major address.
 */
module mat_engine_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           cmd_valid,
    input  mat_ctrl_pkg::host_op_e         cmd_op,
    input  logic [mat_cfg_pkg::ADDR_W-1:0] cmd_addr,
    input  mat_cfg_pkg::operand_t          cmd_data,
    input  logic [mat_cfg_pkg::ADDR_W-1:0] rd_addr,
    output mat_cfg_pkg::acc_t              rd_data,
    output logic                           busy,
    output logic                           done
);
    import mat_cfg_pkg::*;

    // ==============================
    // Internal wiring
    // ==============================
    // Decode to operand bank and execute
    logic              wr_a;
    logic              wr_b;
    logic [ADDR_W-1:0] wr_addr;
    operand_t          wr_data;
    logic              start;
    // Execute to operand bank
    logic [IDX_W-1:0]  row_idx;
    logic [IDX_W-1:0]  k_idx;
    operand_t          a_elem;
    opnd_row_t         b_row;
    // Execute to result store
    logic              row_we;
    logic [IDX_W-1:0]  row_sel;
    acc_row_t          row_data;

    host_cmd_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_valid (cmd_valid),
        .cmd_op    (cmd_op),
        .cmd_addr  (cmd_addr),
        .cmd_data  (cmd_data),
        .busy      (busy),
        .wr_a      (wr_a),
        .wr_b      (wr_b),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .start     (start)
    );

    operand_bank u_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_a    (wr_a),
        .wr_b    (wr_b),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .row_idx (row_idx),
        .k_idx   (k_idx),
        .a_elem  (a_elem),
        .b_row   (b_row)
    );

    matmul_execute u_exec (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .a_elem   (a_elem),
        .b_row    (b_row),
        .row_idx  (row_idx),
        .k_idx    (k_idx),
        .busy     (busy),
        .done     (done),
        .row_we   (row_we),
        .row_sel  (row_sel),
        .row_data (row_data)
    );

    result_store u_result (
        .clk      (clk),
        .rst_n    (rst_n),
        .row_we   (row_we),
        .row_sel  (row_sel),
        .row_data (row_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

endmodule

/* rtl/matmul_execute.sv */
`timescale 1ns/1ps
/*
 * Row-sequenced matrix multiply with one row of MAT_N MAC units.
 * Each row takes MAT_N MAC cycles and one store cycle, so busy is high
 * for exactly MAT_N * (MAT_N + 1) cycles after start is sampled.
 * start is ignored while busy. done holds until the next start.
 */
module matmul_execute (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  mat_cfg_pkg::operand_t         a_elem,
    input  mat_cfg_pkg::opnd_row_t        b_row,
    output logic [mat_cfg_pkg::IDX_W-1:0] row_idx,
    output logic [mat_cfg_pkg::IDX_W-1:0] k_idx,
    output logic                          busy,
    output logic                          done,
    output logic                          row_we,
    output logic [mat_cfg_pkg::IDX_W-1:0] row_sel,
    output mat_cfg_pkg::acc_row_t         row_data
);
    import mat_cfg_pkg::*;
    import mat_ctrl_pkg::*;

    exec_state_e state;
    // One accumulator per result column
    acc_row_t    acc;
    acc_row_t    prod;
    logic        last_k;
    logic        last_row;

    assign last_k   = (k_idx == IDX_W'(MAT_N - 1));
    assign last_row = (row_idx == IDX_W'(MAT_N - 1));

    // ==============================
    // Sequencer
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= EX_IDLE;
            row_idx <= '0;
            k_idx   <= '0;
            done    <= 1'b0;
        end else begin
            case (state)
                EX_IDLE: begin
                    if (start) begin
                        state   <= EX_MAC;
                        row_idx <= '0;
                        k_idx   <= '0;
                        // Old result status cleared as busy rises
                        done    <= 1'b0;
                    end
                end
                EX_MAC: begin
                    // k wraps back to 0 for the next row
                    k_idx <= k_idx + 1'b1;
                    if (last_k) begin
                        state <= EX_STORE;
                    end
                end
                EX_STORE: begin
                    row_idx <= row_idx + 1'b1;
                    if (last_row) begin
                        state <= EX_IDLE;
                        done  <= 1'b1;
                    end else begin
                        state <= EX_MAC;
                    end
                end
                default: state <= EX_IDLE;
            endcase
        end
    end

    // ==============================
    // MAC row
    // ==============================
    // Operands sign-extended to full accumulator width before the multiply
    always_comb begin
        for (int c = 0; c < MAT_N; c++) begin
            prod[c] = acc_t'(a_elem) * acc_t'($signed(b_row[c]));
        end
    end

    // First MAC cycle of a row loads the product, clearing the old sum
    always_ff @(posedge clk) begin
        if (state == EX_MAC) begin
            for (int c = 0; c < MAT_N; c++) begin
                if (k_idx == '0) begin
                    acc[c] <= prod[c];
                end else begin
                    acc[c] <= acc[c] + prod[c];
                end
            end
        end
    end

    // Status and result row write
    assign busy     = (state != EX_IDLE);
    assign row_we   = (state == EX_STORE);
    assign row_sel  = row_idx;
    assign row_data = acc;

endmodule

/* rtl/operand_bank.sv */
`timescale 1ns/1ps
/*
 * Operand storage for matrices A and B, held in registers.
 * One element is written per strobe; a write is visible to reads in
 * the next cycle. Reads are combinational: A[row][k] and all of row k
 * of B, so a full row of MACs can run each cycle.
 */
module operand_bank (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_a,
    input  logic                           wr_b,
    input  logic [mat_cfg_pkg::ADDR_W-1:0] wr_addr,
    input  mat_cfg_pkg::operand_t          wr_data,
    input  logic [mat_cfg_pkg::IDX_W-1:0]  row_idx,
    input  logic [mat_cfg_pkg::IDX_W-1:0]  k_idx,
    output mat_cfg_pkg::operand_t          a_elem,
    output mat_cfg_pkg::opnd_row_t         b_row
);
    import mat_cfg_pkg::*;

    // Both matrices stored as rows of packed elements
    opnd_row_t        mat_a [MAT_N];
    opnd_row_t        mat_b [MAT_N];
    logic [IDX_W-1:0] wr_row;
    logic [IDX_W-1:0] wr_col;

    // Row-major address split
    assign wr_row = wr_addr[ADDR_W-1:IDX_W];
    assign wr_col = wr_addr[IDX_W-1:0];

    // ==============================
    // Write port
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < MAT_N; r++) begin
                mat_a[r] <= '0;
                mat_b[r] <= '0;
            end
        end else begin
            if (wr_a) begin
                mat_a[wr_row][wr_col] <= wr_data;
            end
            if (wr_b) begin
                mat_b[wr_row][wr_col] <= wr_data;
            end
        end
    end

    // ==============================
    // Read ports
    // ==============================
    // Single A element, broadcast to every MAC
    assign a_elem = mat_a[row_idx][k_idx];
    // Whole row k of B, one element per MAC
    assign b_row  = mat_b[k_idx];

endmodule

/* rtl/result_store.sv */
`timescale 1ns/1ps
/*
 * Result matrix storage. A whole row is written per strobe; there is
 * no host write path. Reads are combinational by element address and
 * show a stored row from the cycle after its write edge.
 */
module result_store (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           row_we,
    input  logic [mat_cfg_pkg::IDX_W-1:0]  row_sel,
    input  mat_cfg_pkg::acc_row_t          row_data,
    input  logic [mat_cfg_pkg::ADDR_W-1:0] rd_addr,
    output mat_cfg_pkg::acc_t              rd_data
);
    import mat_cfg_pkg::*;

    acc_row_t         res [MAT_N];
    logic [IDX_W-1:0] rd_row;
    logic [IDX_W-1:0] rd_col;

    // Row write from the execute unit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < MAT_N; r++) begin
                res[r] <= '0;
            end
        end else if (row_we) begin
            res[row_sel] <= row_data;
        end
    end

    // Row-major split, then element mux
    assign rd_row  = rd_addr[ADDR_W-1:IDX_W];
    assign rd_col  = rd_addr[IDX_W-1:0];
    assign rd_data = res[rd_row][rd_col];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the matrix engine testbench with Verilator.
# Exits non-zero unless the simulation output holds the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mat_engine_tb -f mat_engine_top.f -o mat_engine_sim \
    || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/mat_engine_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "NO ERRORS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
